// File: hw/fetchPkg.sv
package fetchPkg;

    // instruction buffer geometry
    localparam int ibDepth = 8;
    localparam int ibAddrW = 3;

    // primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opRegimm  = 6'h01;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opJal     = 6'h03;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opBlez    = 6'h06;
    localparam logic [5:0] opBgtz    = 6'h07;

    // SPECIAL funct codes that jump through a register
    localparam logic [5:0] functJr   = 6'h08;
    localparam logic [5:0] functJalr = 6'h09;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFields_t;

    // same 32 bits, R-type or I-type layout
    typedef union packed {
        rFields_t rView;
        iFields_t iView;
    } instWord_u;

    // 68 bits per buffer entry
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        instWord_u   word;
        logic        isBr;
        logic        isJ;
        logic        isDs;
    } instBundle_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        instWord_u   word;
    } fetchSlot_t;

    typedef struct packed {
        fetchSlot_t slot0;
        fetchSlot_t slot1;
    } fetchPair_t;

    typedef struct packed {
        instBundle_t inst0;
        instBundle_t inst1;
    } bundlePair_t;

endpackage

// File: hw/busPkg.sv
package busPkg;

    localparam int axiAddrW = 8;

    // register map
    localparam logic [axiAddrW-1:0] regCtrl   = 8'h00;
    localparam logic [axiAddrW-1:0] regStatus = 8'h04;
    localparam logic [axiAddrW-1:0] regIssued = 8'h08;

    // bit positions inside the control and status words
    localparam int ctrlDualBit    = 0;
    localparam int ctrlFlushBit   = 1;
    localparam int statusPauseBit = 8;

    localparam logic [1:0] respOkay   = 2'b00;
    localparam logic [1:0] respSlvErr = 2'b10;

    typedef struct packed {
        logic                awvalid;
        logic [axiAddrW-1:0] awaddr;
        logic                wvalid;
        logic [31:0]         wdata;
        logic                bready;
        logic                arvalid;
        logic [axiAddrW-1:0] araddr;
        logic                rready;
    } axiReq_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axiRsp_t;

endpackage

// File: hw/instPredecode.sv
`timescale 1ns/1ps

module instPredecode (
    input  fetchPkg::fetchPair_t  fetchIn,
    output fetchPkg::bundlePair_t decoded
);
    import fetchPkg::*;

    // one fetch slot into one bundle
    function automatic instBundle_t decodeSlot(input fetchSlot_t slot);
        instBundle_t bundle;
        logic        branchOp;
        logic        jumpOp;
        logic        regJump;
        bundle = '0;
        bundle.valid = slot.valid;
        bundle.pc    = slot.pc;
        bundle.word  = slot.word;

        // conditional branches, REGIMM covers bltz/bgez and the link forms
        branchOp = (slot.word.iView.opcode == opBeq) ||
                   (slot.word.iView.opcode == opBne) ||
                   (slot.word.iView.opcode == opBlez) ||
                   (slot.word.iView.opcode == opBgtz) ||
                   (slot.word.iView.opcode == opRegimm);

        jumpOp = (slot.word.rView.opcode == opJ) ||
                 (slot.word.rView.opcode == opJal);

        // jr and jalr sit under SPECIAL
        regJump = (slot.word.rView.opcode == opSpecial) &&
                  ((slot.word.rView.funct == functJr) ||
                   (slot.word.rView.funct == functJalr));

        bundle.isBr = slot.valid && branchOp;
        bundle.isJ  = slot.valid && (jumpOp || regJump);
        bundle.isDs = 1'b0;
        return bundle;
    endfunction

    assign decoded.inst0 = decodeSlot(fetchIn.slot0);
    assign decoded.inst1 = decodeSlot(fetchIn.slot1);

endmodule

// File: hw/instBuffer.sv
`timescale 1ns/1ps

module instBuffer (
    input  logic                  clk,
    input  logic                  arstN,
    input  fetchPkg::bundlePair_t decoded,
    output fetchPkg::bundlePair_t issue,
    output logic                  issueValid,
    input  logic                  issueReady,
    input  logic                  flushIn,
    input  logic                  swFlush,
    input  logic                  dualEnable,
    output logic                  pauseReq,
    output logic [3:0]            occupancy,
    output logic [1:0]            issuedNum
);
    import fetchPkg::*;

    instBundle_t mem [ibDepth];

    // extra top bit on each pointer tells full from empty
    logic [ibAddrW:0]   headPtr;
    logic [ibAddrW:0]   tailPtr;
    logic [ibAddrW:0]   count;
    logic [ibAddrW-1:0] headIdx;
    logic [ibAddrW-1:0] nextIdx;
    logic [ibAddrW-1:0] tailIdx;
    logic [ibAddrW-1:0] tailIdx1;

    logic        flush;
    logic        empty;
    logic        passThrough;
    logic        acceptEn;
    logic        succBuffered;
    logic        headCf;
    logic        succCf;
    logic        inCf1;
    logic [1:0]  wrCount;
    instBundle_t headEntry;
    instBundle_t succEntry;

    // both flush sources merge only here
    assign flush = flushIn || swFlush;

    assign count     = tailPtr - headPtr;
    assign empty     = (count == '0);
    assign occupancy = count;

    // two or fewer free entries left
    assign pauseReq = (count >= (ibAddrW + 1)'(ibDepth - 2));

    assign headIdx  = headPtr[ibAddrW-1:0];
    assign nextIdx  = headIdx + 1'b1;
    assign tailIdx  = tailPtr[ibAddrW-1:0];
    assign tailIdx1 = tailIdx + 1'b1;

    assign headEntry    = mem[headIdx];
    assign succEntry    = mem[nextIdx];
    assign succBuffered = (count > (ibAddrW + 1)'(1));
    assign headCf       = headEntry.isBr || headEntry.isJ;
    assign succCf       = succEntry.isBr || succEntry.isJ;

    // incoming slot1 may not be a branch, its delay slot would be lost
    assign inCf1 = decoded.inst1.isBr || decoded.inst1.isJ;

    assign passThrough = empty && issueReady &&
                         decoded.inst0.valid && decoded.inst1.valid &&
                         !inCf1 && dualEnable && !flush;

    // words offered while paused are dropped
    assign acceptEn = !flush && !pauseReq && !passThrough;
    assign wrCount  = {1'b0, decoded.inst0.valid} + {1'b0, decoded.inst1.valid};

    always_comb begin
        issue      = '0;
        issueValid = 1'b0;
        if (!flush) begin
            if (passThrough) begin
                issueValid  = 1'b1;
                issue.inst0 = decoded.inst0;
                issue.inst1 = decoded.inst1;
            end else if (!empty && !(headCf && !succBuffered)) begin
                // head is ready, pair it with its successor if allowed
                issueValid  = 1'b1;
                issue.inst0 = headEntry;
                if (succBuffered && !succCf && dualEnable) begin
                    issue.inst1 = succEntry;
                end
            end
        end
        issue.inst0.isDs = 1'b0;
        issue.inst1.isDs = issue.inst1.valid && (issue.inst0.isBr || issue.inst0.isJ);
    end

    always_comb begin
        issuedNum = 2'd0;
        if (issueValid && issueReady) begin
            issuedNum = issue.inst1.valid ? 2'd2 : 2'd1;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            headPtr <= '0;
            tailPtr <= '0;
        end else if (flush) begin
            headPtr <= '0;
            tailPtr <= '0;
        end else begin
            // pass-through pairs never touch storage
            if (!passThrough) begin
                headPtr <= headPtr + (ibAddrW + 1)'(issuedNum);
            end
            if (acceptEn) begin
                tailPtr <= tailPtr + (ibAddrW + 1)'(wrCount);
            end
        end
    end

    // entry storage, packed toward the tail
    always_ff @(posedge clk) begin
        if (acceptEn) begin
            if (decoded.inst0.valid) begin
                mem[tailIdx] <= decoded.inst0;
                if (decoded.inst1.valid) begin
                    mem[tailIdx1] <= decoded.inst1;
                end
            end else if (decoded.inst1.valid) begin
                mem[tailIdx] <= decoded.inst1;
            end
        end
    end

endmodule

// File: hw/fetchCsr.sv
`timescale 1ns/1ps

module fetchCsr (
    input  logic            clk,
    input  logic            arstN,
    input  busPkg::axiReq_t axiReq,
    output busPkg::axiRsp_t axiRsp,
    input  logic [3:0]      occupancy,
    input  logic            pauseReq,
    input  logic [1:0]      issuedNum,
    output logic            dualEnable,
    output logic            swFlush
);
    import busPkg::*;

    logic        wrReady;
    logic        bValid;
    logic [1:0]  bResp;
    logic        rdReady;
    logic        rValid;
    logic [31:0] rData;
    logic [1:0]  rResp;
    logic [31:0] issuedCount;
    logic [31:0] rdValue;
    logic        rdHit;
    logic        wrHit;
    logic        wrFire;
    logic        rdFire;
    logic        ctrlWr;
    logic        issuedWr;

    assign wrFire = wrReady && axiReq.awvalid && axiReq.wvalid;
    assign rdFire = rdReady && axiReq.arvalid;

    assign ctrlWr   = wrFire && (axiReq.awaddr == regCtrl);
    assign issuedWr = wrFire && (axiReq.awaddr == regIssued);

    // status is mapped but read only, writes to it are dropped
    assign wrHit = (axiReq.awaddr == regCtrl) ||
                   (axiReq.awaddr == regStatus) ||
                   (axiReq.awaddr == regIssued);

    always_comb begin
        rdValue = '0;
        rdHit   = 1'b1;
        case (axiReq.araddr)
            regCtrl: begin
                // flush bit always reads 0
                rdValue[ctrlDualBit] = dualEnable;
            end
            regStatus: begin
                rdValue[3:0]            = occupancy;
                rdValue[statusPauseBit] = pauseReq;
            end
            regIssued: begin
                rdValue = issuedCount;
            end
            default: begin
                rdHit = 1'b0;
            end
        endcase
    end

    // one outstanding transaction per channel
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrReady <= 1'b0;
            bValid  <= 1'b0;
            rdReady <= 1'b0;
            rValid  <= 1'b0;
        end else begin
            wrReady <= axiReq.awvalid && axiReq.wvalid && !wrReady && !bValid;
            rdReady <= axiReq.arvalid && !rdReady && !rValid;
            if (wrFire) begin
                bValid <= 1'b1;
            end else if (axiReq.bready) begin
                bValid <= 1'b0;
            end
            if (rdFire) begin
                rValid <= 1'b1;
            end else if (axiReq.rready) begin
                rValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wrFire) begin
            bResp <= wrHit ? respOkay : respSlvErr;
        end
        if (rdFire) begin
            rData <= rdValue;
            rResp <= rdHit ? respOkay : respSlvErr;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dualEnable  <= 1'b1;
            swFlush     <= 1'b0;
            issuedCount <= '0;
        end else begin
            swFlush <= ctrlWr && axiReq.wdata[ctrlFlushBit];
            if (ctrlWr) begin
                dualEnable <= axiReq.wdata[ctrlDualBit];
            end
            // software write wins over accumulation, counter wraps
            if (issuedWr) begin
                issuedCount <= axiReq.wdata;
            end else begin
                issuedCount <= issuedCount + 32'(issuedNum);
            end
        end
    end

    always_comb begin
        axiRsp         = '0;
        axiRsp.awready = wrReady;
        axiRsp.wready  = wrReady;
        axiRsp.bvalid  = bValid;
        axiRsp.bresp   = bResp;
        axiRsp.arready = rdReady;
        axiRsp.rvalid  = rValid;
        axiRsp.rdata   = rData;
        axiRsp.rresp   = rResp;
    end

endmodule

// File: hw/fetchFrontEnd.sv
`timescale 1ns/1ps

module fetchFrontEnd (
    input  logic                  clk,
    input  logic                  arstN,
    input  fetchPkg::fetchPair_t  fetchIn,
    output logic                  fetchPause,
    output fetchPkg::bundlePair_t issue,
    output logic                  issueValid,
    input  logic                  issueReady,
    input  logic                  flushIn,
    input  busPkg::axiReq_t       axiReq,
    output busPkg::axiRsp_t       axiRsp
);
    import fetchPkg::*;

    bundlePair_t decoded;
    logic        dualEnable;
    logic        swFlush;
    logic [3:0]  occupancy;
    logic [1:0]  issuedNum;

    instPredecode instPredecode_i (
        .fetchIn (fetchIn),
        .decoded (decoded)
    );

    // pause request goes straight back to fetch
    instBuffer instBuffer_i (
        .clk        (clk),
        .arstN      (arstN),
        .decoded    (decoded),
        .issue      (issue),
        .issueValid (issueValid),
        .issueReady (issueReady),
        .flushIn    (flushIn),
        .swFlush    (swFlush),
        .dualEnable (dualEnable),
        .pauseReq   (fetchPause),
        .occupancy  (occupancy),
        .issuedNum  (issuedNum)
    );

    fetchCsr fetchCsr_i (
        .clk        (clk),
        .arstN      (arstN),
        .axiReq     (axiReq),
        .axiRsp     (axiRsp),
        .occupancy  (occupancy),
        .pauseReq   (fetchPause),
        .issuedNum  (issuedNum),
        .dualEnable (dualEnable),
        .swFlush    (swFlush)
    );

endmodule

// File: tb/tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk
);
    // 100 ns period
    localparam int halfPeriod = 50;

    initial begin
        clk = 1'b0;
        forever begin
            #halfPeriod clk = ~clk;
        end
    end

endmodule

// File: tb/instBuffer_checker.sv
`timescale 1ns/1ps

module instBuffer_checker (
    input logic                       clk,
    input logic                       arstN,
    input logic                       flush,
    input logic                       issueValid,
    input logic [3:0]                 occupancy,
    input logic                       pauseReq,
    input logic [fetchPkg::ibAddrW:0] tailPtr,
    input logic                       inst0Valid,
    input logic                       inst1Valid
);
    import fetchPkg::*;

    // polled by the testbench
    int failCount = 0;

    noIssueInFlush: assert property (@(posedge clk) disable iff (!arstN)
        flush |-> !issueValid)
        else begin
            $error("issueValid high during a flush");
            failCount++;
        end

    occupancyBound: assert property (@(posedge clk) disable iff (!arstN)
        occupancy <= 4'(ibDepth))
        else begin
            $error("occupancy above buffer depth");
            failCount++;
        end

    // a flush may still reset the tail
    tailHeldInPause: assert property (@(posedge clk) disable iff (!arstN)
        (pauseReq && !flush) |=> (tailPtr == $past(tailPtr)))
        else begin
            $error("tail moved while paused");
            failCount++;
        end

    pairOrder: assert property (@(posedge clk) disable iff (!arstN)
        inst1Valid |-> inst0Valid)
        else begin
            $error("inst1 valid without inst0");
            failCount++;
        end

endmodule

bind instBuffer instBuffer_checker bufferChecks (
    .clk        (clk),
    .arstN      (arstN),
    .flush      (flush),
    .issueValid (issueValid),
    .occupancy  (occupancy),
    .pauseReq   (pauseReq),
    .tailPtr    (tailPtr),
    .inst0Valid (issue.inst0.valid),
    .inst1Valid (issue.inst1.valid)
);

// File: tb/fetchFrontEnd_tb.sv
`timescale 1ns/1ps

module fetchFrontEnd_tb;
    import fetchPkg::*;
    import busPkg::*;

    localparam int goldenLines = 30;
    localparam int goldenCols  = 18;
    // worst case cycles spent on one register access
    localparam int axiCycles   = 6;

    logic        clk;
    logic        arstN;
    fetchPair_t  fetchIn;
    logic        fetchPause;
    bundlePair_t issue;
    logic        issueValid;
    logic        issueReady;
    logic        flushIn;
    axiReq_t     axiReq;
    axiRsp_t     axiRsp;

    logic [31:0] golden [goldenLines * goldenCols];
    int          issuedTotal;
    int          cycleCount = 0;
    int          cycleLimit;

    tbClock clockGen (.clk(clk));

    fetchFrontEnd fetchFrontEnd_i (
        .clk        (clk),
        .arstN      (arstN),
        .fetchIn    (fetchIn),
        .fetchPause (fetchPause),
        .issue      (issue),
        .issueValid (issueValid),
        .issueReady (issueReady),
        .flushIn    (flushIn),
        .axiReq     (axiReq),
        .axiRsp     (axiRsp)
    );

    task automatic failRun(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkBit(input logic expected, input logic actual, input string name);
        if (actual !== expected) begin
            failRun($sformatf("CHECK FAILED at %0t: %s expected %0b, got %0b",
                              $time, name, expected, actual));
        end
    endtask

    task automatic checkWord(input logic [31:0] expected, input logic [31:0] actual,
                             input string name);
        if (actual !== expected) begin
            failRun($sformatf("CHECK FAILED at %0t: %s expected %h, got %h",
                              $time, name, expected, actual));
        end
    endtask

    // remaining fields only matter for a valid bundle
    task automatic checkBundle(input instBundle_t expected, input instBundle_t actual,
                               input string name);
        checkBit(expected.valid, actual.valid, {name, ".valid"});
        if (expected.valid) begin
            checkWord(expected.pc, actual.pc, {name, ".pc"});
            checkWord(expected.word, actual.word, {name, ".word"});
            checkBit(expected.isBr, actual.isBr, {name, ".isBr"});
            checkBit(expected.isJ, actual.isJ, {name, ".isJ"});
            checkBit(expected.isDs, actual.isDs, {name, ".isDs"});
        end
    endtask

    // word that the stimulus offered at this pc
    function automatic logic [31:0] wordAtPc(input logic [31:0] pc);
        logic [31:0] word;
        int          base;
        word = '0;
        for (int ln = 0; ln < goldenLines; ln++) begin
            base = ln * goldenCols;
            if (golden[base + 2][0] && (golden[base + 3] == pc)) begin
                word = golden[base + 4];
            end
            if (golden[base + 5][0] && (golden[base + 6] == pc)) begin
                word = golden[base + 7];
            end
        end
        return word;
    endfunction

    // REGIMM group plus beq, bne, blez and bgtz
    function automatic logic isBranchWord(input logic [31:0] w);
        return w[31:26] inside {6'h01, 6'h04, 6'h05, 6'h06, 6'h07};
    endfunction

    // j and jal, or jr and jalr under SPECIAL
    function automatic logic isJumpWord(input logic [31:0] w);
        return (w[31:26] inside {6'h02, 6'h03}) ||
               ((w[31:26] == 6'h00) && (w[5:0] inside {6'h08, 6'h09}));
    endfunction

    task automatic idleInputs();
        fetchIn    = '0;
        issueReady = 1'b0;
        flushIn    = 1'b0;
    endtask

    task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
        @(negedge clk);
        axiReq.awvalid = 1'b1;
        axiReq.awaddr  = addr;
        axiReq.wvalid  = 1'b1;
        axiReq.wdata   = data;
        @(negedge clk);
        while (!axiRsp.awready) begin
            @(negedge clk);
        end
        // awready and wready pulse together
        checkBit(1'b1, axiRsp.wready, "wready");
        // handshake completes on the rising edge in between
        @(negedge clk);
        axiReq.awvalid = 1'b0;
        axiReq.wvalid  = 1'b0;
        axiReq.bready  = 1'b1;
        while (!axiRsp.bvalid) begin
            @(negedge clk);
        end
        resp = axiRsp.bresp;
        @(negedge clk);
        axiReq.bready = 1'b0;
    endtask

    task automatic axiRead(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
        @(negedge clk);
        axiReq.arvalid = 1'b1;
        axiReq.araddr  = addr;
        @(negedge clk);
        while (!axiRsp.arready) begin
            @(negedge clk);
        end
        @(negedge clk);
        axiReq.arvalid = 1'b0;
        axiReq.rready  = 1'b1;
        while (!axiRsp.rvalid) begin
            @(negedge clk);
        end
        data = axiRsp.rdata;
        resp = axiRsp.rresp;
        @(negedge clk);
        axiReq.rready = 1'b0;
    endtask

    // register access requested by the first two golden columns
    task automatic runAction(input logic [31:0] act, input logic [31:0] arg);
        logic [1:0]  resp;
        logic [31:0] data;
        if (act != 0) begin
            @(negedge clk);
            idleInputs();
            case (act)
                1: begin
                    axiWrite(regCtrl, arg, resp);
                    checkWord(32'(respOkay), 32'(resp), "bresp");
                end
                2: begin
                    axiRead(regStatus, data, resp);
                    checkWord(arg, data, "regStatus");
                    checkWord(32'(respOkay), 32'(resp), "rresp");
                end
                3: begin
                    axiRead(regIssued, data, resp);
                    checkWord(32'(issuedTotal), data, "regIssued");
                    checkWord(32'(respOkay), 32'(resp), "rresp");
                end
                4: begin
                    axiRead(arg[7:0], data, resp);
                    checkWord(32'(respSlvErr), 32'(resp), "rresp");
                end
                default: begin
                    failRun("unknown action code in the golden file");
                end
            endcase
        end
    endtask

    task automatic applyLine(input int ln);
        logic [31:0] f [goldenCols];
        instBundle_t expected0;
        instBundle_t expected1;
        for (int c = 0; c < goldenCols; c++) begin
            f[c] = golden[ln * goldenCols + c];
        end
        runAction(f[0], f[1]);
        @(negedge clk);
        fetchIn.slot0.valid = f[2][0];
        fetchIn.slot0.pc    = f[3];
        fetchIn.slot0.word  = f[4];
        fetchIn.slot1.valid = f[5][0];
        fetchIn.slot1.pc    = f[6];
        fetchIn.slot1.word  = f[7];
        issueReady          = f[8][0];
        flushIn             = f[9][0];
        // just before the next rising edge
        #45;
        expected0       = '0;
        expected0.valid = f[11][0];
        expected0.pc    = f[12];
        expected0.word  = wordAtPc(f[12]);
        expected0.isBr  = isBranchWord(expected0.word);
        expected0.isJ   = isJumpWord(expected0.word);
        expected0.isDs  = f[13][0];
        expected1       = '0;
        expected1.valid = f[14][0];
        expected1.pc    = f[15];
        expected1.word  = wordAtPc(f[15]);
        expected1.isBr  = isBranchWord(expected1.word);
        expected1.isJ   = isJumpWord(expected1.word);
        expected1.isDs  = f[16][0];
        checkBit(f[10][0], issueValid, "issueValid");
        checkBundle(expected0, issue.inst0, "issue.inst0");
        checkBundle(expected1, issue.inst1, "issue.inst1");
        checkBit(f[17][0], fetchPause, "fetchPause");
        // instructions moved in this cycle per the golden model
        if (f[10][0] && f[8][0]) begin
            issuedTotal += f[14][0] ? 2 : 1;
        end
        if (fetchFrontEnd_i.instBuffer_i.bufferChecks.failCount != 0) begin
            failRun("a buffer assertion failed");
        end
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("simulation timed out");
            $display("ERRORS FOUND");
            $fatal(1, "cycle limit reached");
        end
    end

    initial begin
        int actionCount;
        actionCount = 0;
        arstN       = 1'b0;
        axiReq      = '0;
        issuedTotal = 0;
        idleInputs();
        $readmemh("tb/fetchGolden.txt", golden);
        for (int ln = 0; ln < goldenLines; ln++) begin
            if (golden[ln * goldenCols] != 0) begin
                actionCount++;
            end
        end
        cycleLimit = goldenLines + axiCycles * actionCount + 50;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        for (int ln = 0; ln < goldenLines; ln++) begin
            applyLine(ln);
        end
        // let the last cycle's assertions run
        @(negedge clk);
        if (fetchFrontEnd_i.instBuffer_i.bufferChecks.failCount != 0) begin
            failRun("a buffer assertion failed");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

// File: fetchFrontEnd.f
hw/fetchPkg.sv
hw/busPkg.sv
hw/instPredecode.sv
hw/instBuffer.sv
hw/fetchCsr.sv
hw/fetchFrontEnd.sv
tb/tbClock.sv
tb/instBuffer_checker.sv
tb/fetchFrontEnd_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= fetchFrontEnd_tb
FILELIST  ?= fetchFrontEnd.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUNFLAGS  ?= +verilator+error+limit+100
PASSTEXT  ?= NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@output="$$(./$(OBJDIR)/V$(TOP) $(RUNFLAGS) 2>&1)"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)

// File: tb/fetchGolden.txt
// act arg | slot0 v pc word | slot1 v pc word | ready flush | issueValid | inst0 v pc ds | inst1 v pc ds | pause
// act: 0 none, 1 write regCtrl arg, 2 read regStatus expect arg, 3 read regIssued, 4 read offset arg
0 0 1 100 24010001 1 104 24010001 1 0 1 1 100 0 1 104 0 0
0 0 1 108 10000004 1 10c 24010001 1 0 1 1 108 0 1 10c 1 0
0 0 1 110 24010001 1 114 08000010 1 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 1 0 1 1 110 0 0 0 0 0
0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0
0 0 1 118 24010001 0 0 0 1 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 1 0 1 1 114 0 1 118 1 0
0 0 1 120 24010001 1 124 24010001 0 0 0 0 0 0 0 0 0 0
0 0 1 128 24010001 1 12c 24010001 0 0 1 1 120 0 1 124 0 0
0 0 1 130 24010001 1 134 24010001 0 0 1 1 120 0 1 124 0 0
0 0 1 138 24010001 1 13c 24010001 0 0 1 1 120 0 1 124 0 1
0 0 1 140 24010001 1 144 24010001 1 0 1 1 120 0 1 124 0 1
0 0 0 0 0 0 0 0 1 0 1 1 128 0 1 12c 0 0
0 0 0 0 0 0 0 0 1 0 1 1 130 0 1 134 0 0
0 0 1 150 24010001 1 154 10000004 0 0 0 0 0 0 0 0 0 0
0 0 1 158 24010001 1 15c 24010001 0 1 0 0 0 0 0 0 0 0
0 0 1 160 24010001 0 0 0 1 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 1 0 1 1 160 0 0 0 0 0
0 0 1 170 24010001 1 174 24010001 0 0 0 0 0 0 0 0 0 0
1 3 1 180 24010001 0 0 0 1 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 1 0 1 1 180 0 0 0 0 0
0 0 1 190 24010001 1 194 24010001 0 0 0 0 0 0 0 0 0 0
2 2 0 0 0 0 0 0 0 0 1 1 190 0 1 194 0 0
1 0 0 0 0 0 0 0 1 0 1 1 190 0 0 0 0 0
0 0 0 0 0 0 0 0 1 0 1 1 194 0 0 0 0 0
0 0 1 1a0 24010001 1 1a4 24010001 1 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 1 0 1 1 1a0 0 0 0 0 0
0 0 0 0 0 0 0 0 1 0 1 1 1a4 0 0 0 0 0
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
4 10 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
